/* bench/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker (
	input logic              clk,
	input logic              rst_n,
	input cpu_pkg::mem_req_t host_req,
	input cpu_pkg::mem_req_t core_req,
	input logic              core_gnt,
	input cpu_pkg::ctrl_t    ctrl
);

	// host has fixed priority
	host_wins: assert property (@(posedge clk) disable iff (!rst_n)
		host_req.req |-> !core_gnt)
		else $error("core granted while the host is requesting");

	// a denied core request is held unchanged
	core_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(core_req.req && !core_gnt) |=> $stable(core_req))
		else $error("core request changed while waiting for grant");

	one_write_kind: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.we_m && ctrl.we_r))
		else $error("control word writes both memory and register file");

endmodule

// top level sees both requesters, the control word comes from the core's decoder
bind cpu_top cpu_checker u_chk (
	.clk, .rst_n, .host_req, .core_req, .core_gnt, .ctrl(u_core.ctrl)
);

/* bench/cpu_monitor.sv */
`timescale 1ns/1ps

module cpu_monitor (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cpu_pkg::mem_req_t        host_req,
	input  logic [cpu_pkg::XLEN-1:0] host_rdata,
	input  logic                     halted,
	input  logic [cpu_pkg::XLEN-1:0] exp_data,
	output int                       errors,
	output int                       reads,
	output int                       halts
);

	logic                     pending;
	logic                     halted_q;
	logic [cpu_pkg::XLEN-1:0] exp_q;

	always @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
			halted_q <= 1'b0;
			exp_q <= '0;
			errors <= 0;
			reads <= 0;
			halts <= 0;
		end else begin
			// host is granted in the request cycle, data follows one cycle later
			pending <= host_req.req && !host_req.we;
			exp_q <= exp_data;
			halted_q <= halted;
			if (halted && !halted_q)
				halts <= halts + 1;
			if (pending) begin
				reads <= reads + 1;
				if (host_rdata !== exp_q) begin
					$display("Mismatch at %0d ns: host read returned %h, expected %h",
						$time, host_rdata, exp_q);
					errors <= errors + 1;
				end
			end
		end
	end

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	localparam logic [31:0] SEED_ADDR = 32'h200;
	localparam logic [31:0] RES_ADDR = 32'h208;
	localparam int RUN_LIMIT = 200;

	logic              clk;
	logic              rst_n;
	logic              run;
	cpu_pkg::mem_req_t host_req;
	logic [31:0]       host_rdata;
	logic              halted;
	logic [31:0]       exp_data;
	int                mon_errors;
	int                mon_reads;
	int                mon_halts;
	int                timeouts;
	int                failed;

	// test table, eight program words per test
	string       names[$];
	logic [31:0] seeds0[$];
	logic [31:0] seeds1[$];
	logic [31:0] res_addrs[$];
	logic [31:0] exps[$];
	logic [31:0] progs[$];

	cpu_top u_dut (.clk, .rst_n, .run, .host_req, .host_rdata, .halted);

	cpu_monitor u_mon (
		.clk, .rst_n, .host_req, .host_rdata, .halted, .exp_data,
		.errors(mon_errors), .reads(mon_reads), .halts(mon_halts)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f, input logic [4:0] rd);
		return {f7, rs2, rs1, f, rd, cpu_pkg::OP_R};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
		input logic [4:0] rs1, input logic [2:0] f, input logic [4:0] rd);
		return {imm, rs1, f, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f);
		return {imm[11:5], rs2, rs1, f, imm[4:0], cpu_pkg::OP_S};
	endfunction

	function automatic logic [31:0] enc_sb(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f);
		logic [11:0] fld;
		fld = off[12:1];
		return {fld[11:5], rs2, rs1, f, fld[4:0], cpu_pkg::OP_SB};
	endfunction

	function automatic logic [31:0] enc_uj(input logic [20:0] off, input logic [4:0] rd);
		return {off[20:1], rd, cpu_pkg::OP_UJ};
	endfunction

	task automatic add_test(input string name, input logic [31:0] s0, input logic [31:0] s1,
		input logic [31:0] p0, input logic [31:0] p1, input logic [31:0] p2,
		input logic [31:0] p3, input logic [31:0] p4, input logic [31:0] p5,
		input logic [31:0] p6, input logic [31:0] res, input logic [31:0] exp);
		names.push_back(name);
		seeds0.push_back(s0);
		seeds1.push_back(s1);
		res_addrs.push_back(res);
		exps.push_back(exp);
		progs.push_back(p0);
		progs.push_back(p1);
		progs.push_back(p2);
		progs.push_back(p3);
		progs.push_back(p4);
		progs.push_back(p5);
		progs.push_back(p6);
		// last slot stays a halt
		progs.push_back(32'h0);
	endtask

	// x3 = x1 op x2, stored at the result word
	task automatic rr_test(input string name, input logic [6:0] f7, input logic [2:0] f,
		input logic [31:0] s0, input logic [31:0] s1, input logic [31:0] exp);
		add_test(name, s0, s1, enc_i(cpu_pkg::OP_I, 12'h200, 0, 3'b001, 1),
			enc_i(cpu_pkg::OP_I, 12'h204, 0, 3'b001, 2), enc_r(f7, 2, 1, f, 3),
			enc_s(12'h208, 3, 0, 3'b010), 0, 0, 0, RES_ADDR, exp);
	endtask

	task automatic ri_test(input string name, input logic [2:0] f, input logic [11:0] imm,
		input logic [31:0] s0, input logic [31:0] exp);
		add_test(name, s0, 32'h0, enc_i(cpu_pkg::OP_I, 12'h200, 0, 3'b001, 1),
			enc_i(cpu_pkg::OP_R_I, imm, 1, f, 3), enc_s(12'h208, 3, 0, 3'b010),
			0, 0, 0, 0, RES_ADDR, exp);
	endtask

	task automatic load_test(input string name, input logic [2:0] f, input logic [11:0] addr,
		input logic [31:0] exp);
		add_test(name, 32'h80FF7F01, 32'h0, enc_i(cpu_pkg::OP_I, addr, 0, f, 3),
			enc_s(12'h208, 3, 0, 3'b010), 0, 0, 0, 0, 0, RES_ADDR, exp);
	endtask

	// preset word sits at 0x204
	task automatic store_test(input string name, input logic [2:0] f, input logic [11:0] addr,
		input logic [31:0] exp);
		add_test(name, 32'h11223344, 32'hAABBCCDD, enc_i(cpu_pkg::OP_I, 12'h200, 0, 3'b001, 1),
			enc_s(addr, 1, 0, f), 0, 0, 0, 0, 0, 32'h204, exp);
	endtask

	// not taken stores x1, taken skips to a store of x0
	task automatic branch_test(input string name, input logic [2:0] f,
		input logic [31:0] s0, input logic [31:0] s1, input logic [31:0] exp);
		add_test(name, s0, s1, enc_i(cpu_pkg::OP_I, 12'h200, 0, 3'b001, 1),
			enc_i(cpu_pkg::OP_I, 12'h204, 0, 3'b001, 2), enc_sb(13'd12, 2, 1, f),
			enc_s(12'h208, 1, 0, 3'b010), 0, enc_s(12'h208, 0, 0, 3'b010), 0, RES_ADDR, exp);
	endtask

	task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		host_req = '{req: 1'b1, we: 1'b1, be: 4'hF, addr: addr, wdata: data};
	endtask

	task automatic host_read(input logic [31:0] addr, input logic [31:0] exp);
		@(posedge clk);
		#1;
		exp_data = exp;
		host_req = '{req: 1'b1, we: 1'b0, be: 4'h0, addr: addr, wdata: 32'h0};
	endtask

	task automatic host_idle();
		@(posedge clk);
		#1;
		host_req = '0;
	endtask

	task automatic run_test(input int i);
		int   cyc;
		int   err_before;
		logic ok;
		err_before = mon_errors;
		for (int k = 0; k < 8; k++)
			host_write(k * 4, progs[i*8+k]);
		host_write(res_addrs[i], 32'hDEADBEEF);
		host_write(SEED_ADDR, seeds0[i]);
		host_write(SEED_ADDR + 4, seeds1[i]);
		host_idle();
		run = 1'b1;
		cyc = 0;
		// odd tests compete with host reads while the core runs
		while (!halted && cyc < RUN_LIMIT) begin
			if ((i % 2 == 1) && (cyc % 3 == 0))
				host_read(SEED_ADDR, seeds0[i]);
			else
				host_idle();
			cyc++;
		end
		host_idle();
		ok = halted;
		run = 1'b0;
		if (!ok) begin
			timeouts++;
			$display("test %s: the core did not halt within %0d cycles", names[i], RUN_LIMIT);
		end
		host_read(res_addrs[i], exps[i]);
		host_idle();
		host_idle();
		if (ok)
			$display("test %s: %s", names[i], (mon_errors == err_before) ? "ok" : "failed");
		if (!ok || mon_errors != err_before)
			failed++;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		host_req = '0;
		exp_data = '0;
		timeouts = 0;
		failed = 0;

		rr_test("add", 7'h00, 3'b000, 32'h12345678, 32'h11111111, 32'h23456789);
		rr_test("sub", 7'h20, 3'b000, 32'd5, 32'd7, 32'hFFFFFFFE);
		rr_test("slt", 7'h00, 3'b001, 32'hFFFFFFFF, 32'd1, 32'd1);
		rr_test("sltu", 7'h00, 3'b010, 32'hFFFFFFFF, 32'd1, 32'd0);
		rr_test("xor", 7'h00, 3'b101, 32'hF0F0F0F0, 32'h0FF00FF0, 32'hFF00FF00);
		rr_test("sra", 7'h20, 3'b001, 32'h80000010, 32'd4, 32'hF8000001);
		rr_test("sll", 7'h00, 3'b110, 32'h0000000F, 32'h00000108, 32'h00000F00);
		ri_test("addi_neg", 3'b000, 12'hFFD, 32'd10, 32'd7);
		ri_test("xori_neg", 3'b100, 12'hFFF, 32'h12345678, 32'hEDCBA987);
		load_test("lb_off0", 3'b100, 12'h200, 32'h00000001);
		load_test("lb_off1", 3'b100, 12'h201, 32'h0000007F);
		load_test("lb_off2", 3'b100, 12'h202, 32'hFFFFFFFF);
		load_test("lbu_off3", 3'b101, 12'h203, 32'h00000080);
		load_test("lh_off2", 3'b010, 12'h202, 32'hFFFF80FF);
		load_test("lhu_off2", 3'b011, 12'h202, 32'h000080FF);
		load_test("lhu_off0", 3'b011, 12'h200, 32'h00007F01);
		store_test("sb_off1", 3'b001, 12'h205, 32'hAABB44DD);
		store_test("sb_off3", 3'b001, 12'h207, 32'h44BBCCDD);
		store_test("sh_off2", 3'b011, 12'h206, 32'h3344CCDD);
		branch_test("beq_taken", 3'b000, 32'd7, 32'd7, 32'd0);
		branch_test("beq_not", 3'b000, 32'd7, 32'd8, 32'd7);
		branch_test("bne_taken", 3'b001, 32'd7, 32'd8, 32'd0);
		branch_test("bne_not", 3'b001, 32'd9, 32'd9, 32'd9);
		branch_test("blt_taken", 3'b100, 32'hFFFFFFF0, 32'd3, 32'd0);
		branch_test("blt_not", 3'b100, 32'd3, 32'hFFFFFFF0, 32'd3);
		branch_test("bltu_taken", 3'b110, 32'd3, 32'hFFFFFFF0, 32'd0);
		branch_test("bltu_not", 3'b110, 32'hFFFFFFF0, 32'd3, 32'hFFFFFFF0);
		// link register holds pc+4 of the jump
		add_test("jal_link", 32'h0, 32'h0, enc_uj(21'd12, 5), enc_s(12'h208, 0, 0, 3'b010),
			0, enc_s(12'h208, 5, 0, 3'b010), 0, 0, 0, RES_ADDR, 32'd4);

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < names.size(); i++)
			run_test(i);

		if (mon_halts != names.size() - timeouts) begin
			$display("halt count %0d does not match the %0d completed runs",
				mon_halts, names.size() - timeouts);
			failed++;
		end
		$display("%0d tests, %0d failed, %0d timeouts, %0d host reads, %0d mismatches",
			names.size(), failed, timeouts, mon_reads, mon_errors);
		if (failed == 0 && mon_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* cpu_mini.f */
src/cpu_pkg.sv
src/cpu_cntr.sv
src/cpu_alu.sv
src/cpu_regfile.sv
src/cpu_core.sv
src/mem_arbiter.sv
src/shared_mem.sv
src/cpu_top.sv
bench/cpu_checker.sv
bench/cpu_monitor.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f cpu_mini.f --top-module cpu_tb -o cpu_sim \
	&& ./obj_dir/cpu_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
! grep -q "\*\* FAIL \*\*" sim.log && grep -q "\*\* PASS \*\*" sim.log || exit 1

/* src/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu (
	input  logic [cpu_pkg::XLEN-1:0] a,
	input  logic [cpu_pkg::XLEN-1:0] b,
	input  cpu_pkg::alu_op_t         op,
	output logic [cpu_pkg::XLEN-1:0] y,
	output logic                     zero,
	output logic                     less
);

	logic       lt_s;
	logic       lt_u;
	logic [4:0] shamt;

	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD:  y = a + b;
			cpu_pkg::ALU_SUB:  y = a - b;
			cpu_pkg::ALU_SLT:  y = {{(cpu_pkg::XLEN-1){1'b0}}, lt_s};
			cpu_pkg::ALU_SLTU: y = {{(cpu_pkg::XLEN-1){1'b0}}, lt_u};
			cpu_pkg::ALU_AND:  y = a & b;
			cpu_pkg::ALU_OR:   y = a | b;
			cpu_pkg::ALU_XOR:  y = a ^ b;
			cpu_pkg::ALU_SLL:  y = a << shamt;
			cpu_pkg::ALU_SRL:  y = a >> shamt;
			cpu_pkg::ALU_SRA:  y = $signed(a) >>> shamt;
			default:           y = '0;
		endcase
	end

	assign zero = (y == '0);
	// unsigned view only for sltu
	assign less = (op == cpu_pkg::ALU_SLTU) ? lt_u : lt_s;

endmodule

/* src/cpu_cntr.sv */
`timescale 1ns/1ps

module cpu_cntr (
	input  logic [6:0]     opcode,
	input  logic [2:0]     fnct,
	input  logic [6:0]     fnct7,
	output cpu_pkg::ctrl_t ctrl
);

	always_comb begin
		// default is a no-write nop
		ctrl = '0;
		case (opcode)
			cpu_pkg::OP_R: begin
				if (fnct7 == 7'b0000000) begin
					ctrl.we_r = 1'b1;
					case (fnct)
						3'b000: ctrl.alu_op = cpu_pkg::ALU_ADD;
						3'b001: ctrl.alu_op = cpu_pkg::ALU_SLT;
						3'b010: ctrl.alu_op = cpu_pkg::ALU_SLTU;
						3'b011: ctrl.alu_op = cpu_pkg::ALU_AND;
						3'b100: ctrl.alu_op = cpu_pkg::ALU_OR;
						3'b101: ctrl.alu_op = cpu_pkg::ALU_XOR;
						3'b110: ctrl.alu_op = cpu_pkg::ALU_SLL;
						default: ctrl.alu_op = cpu_pkg::ALU_SRL;
					endcase
				end else if (fnct7 == 7'b0100000) begin
					ctrl.we_r = (fnct == 3'b000) || (fnct == 3'b001);
					ctrl.alu_op = (fnct == 3'b001) ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SUB;
				end
			end
			cpu_pkg::OP_R_I: begin
				ctrl.we_r = 1'b1;
				ctrl.src_imm = 1'b1;
				ctrl.imm_kind = cpu_pkg::IMM_I;
				case (fnct)
					3'b000: ctrl.alu_op = cpu_pkg::ALU_ADD;
					3'b001: ctrl.alu_op = cpu_pkg::ALU_SLT;
					3'b010: ctrl.alu_op = cpu_pkg::ALU_AND;
					3'b011: ctrl.alu_op = cpu_pkg::ALU_OR;
					3'b100: ctrl.alu_op = cpu_pkg::ALU_XOR;
					3'b101: ctrl.alu_op = cpu_pkg::ALU_SLL;
					3'b110: ctrl.alu_op = cpu_pkg::ALU_SRL;
					default: ctrl.alu_op = cpu_pkg::ALU_SRA;
				endcase
			end
			cpu_pkg::OP_I: begin
				ctrl.src_imm = 1'b1;
				ctrl.imm_kind = cpu_pkg::IMM_I;
				ctrl.ext = (fnct >= 3'b100) ? cpu_pkg::EXT_B :
					(fnct >= 3'b010) ? cpu_pkg::EXT_H : cpu_pkg::EXT_W;
				// even codes 010 and 100 are the signed loads
				ctrl.signed_ext = (fnct == 3'b010) || (fnct == 3'b100);
				ctrl.mem_rd = (fnct >= 3'b001) && (fnct <= 3'b101);
				ctrl.we_r = ctrl.mem_rd;
			end
			cpu_pkg::OP_S: begin
				ctrl.src_imm = 1'b1;
				ctrl.imm_kind = cpu_pkg::IMM_S;
				case (fnct)
					3'b001: ctrl.byte_en = 4'b0001;
					3'b010: ctrl.byte_en = 4'b1111;
					3'b011: ctrl.byte_en = 4'b0011;
					default: ctrl.byte_en = 4'b0000;
				endcase
				ctrl.we_m = |ctrl.byte_en;
			end
			cpu_pkg::OP_SB: begin
				ctrl.imm_kind = cpu_pkg::IMM_SB;
				ctrl.alu_op = (fnct == 3'b110) ? cpu_pkg::ALU_SLTU : cpu_pkg::ALU_SUB;
				ctrl.brch = fnct inside {3'b000, 3'b001, 3'b100, 3'b110};
			end
			cpu_pkg::OP_UJ: begin
				ctrl.imm_kind = cpu_pkg::IMM_UJ;
				ctrl.jump = 1'b1;
				ctrl.wb_pc4 = 1'b1;
				ctrl.we_r = 1'b1;
			end
			cpu_pkg::OP_HALT: ctrl.halt = 1'b1;
			default: ctrl.halt = 1'b0;
		endcase
	end

endmodule

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     run,
	output cpu_pkg::mem_req_t        core_req,
	input  logic                     core_gnt,
	input  logic [cpu_pkg::XLEN-1:0] core_rdata,
	output logic                     halted
);

	typedef enum logic [2:0] {S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB} state_t;

	state_t                   state;
	cpu_pkg::ctrl_t           ctrl;
	logic [cpu_pkg::XLEN-1:0] pc, pc4, pc_next, ir, imm;
	logic [cpu_pkg::XLEN-1:0] rd1, rd2, alu_b, alu_y, ld_data, wd;
	logic [15:0]              ld_half;
	logic [7:0]               ld_byte;
	logic [1:0]               off;
	logic                     zero, less, br_cond, rf_we;

	cpu_cntr u_cntr (.opcode(ir[6:0]), .fnct(ir[14:12]), .fnct7(ir[31:25]), .ctrl(ctrl));

	cpu_regfile u_rf (
		.clk, .rst_n, .ra1(ir[19:15]), .ra2(ir[24:20]), .rd1, .rd2,
		.wa(ir[11:7]), .wd, .we(rf_we)
	);

	cpu_alu u_alu (.a(rd1), .b(alu_b), .op(ctrl.alu_op), .y(alu_y), .zero, .less);

	always_comb begin
		case (ctrl.imm_kind)
			cpu_pkg::IMM_I:  imm = {{20{ir[31]}}, ir[31:20]};
			cpu_pkg::IMM_S:  imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			cpu_pkg::IMM_SB: imm = {{19{ir[31]}}, ir[31:25], ir[11:7], 1'b0};
			default:         imm = {{11{ir[31]}}, ir[31:12], 1'b0};
		endcase
	end

	assign alu_b = ctrl.src_imm ? imm : rd2;
	assign pc4 = pc + 32'd4;
	assign off = alu_y[1:0];

	// beq, bne, then blt/bltu through less
	assign br_cond = (ir[14:12] == 3'b000) ? zero : (ir[14:12] == 3'b001) ? !zero : less;
	assign pc_next = ((ctrl.brch && br_cond) || ctrl.jump) ? pc + imm : pc4;

	// load lane select and extension
	assign ld_half = off[1] ? core_rdata[31:16] : core_rdata[15:0];
	assign ld_byte = core_rdata[{off, 3'b000} +: 8];
	always_comb begin
		case (ctrl.ext)
			cpu_pkg::EXT_H: ld_data = {{16{ctrl.signed_ext & ld_half[15]}}, ld_half};
			cpu_pkg::EXT_B: ld_data = {{24{ctrl.signed_ext & ld_byte[7]}}, ld_byte};
			default:        ld_data = core_rdata;
		endcase
	end

	assign wd = (state == S_WB) ? ld_data : (ctrl.wb_pc4 ? pc4 : alu_y);
	assign rf_we = (state == S_WB) || (state == S_EXEC && ctrl.we_r && !ctrl.mem_rd);

	always_comb begin
		core_req = '0;
		if (state == S_FETCH) begin
			core_req.req = 1'b1;
			core_req.addr = pc;
		end else if (state == S_MEM) begin
			core_req.req = 1'b1;
			core_req.we = ctrl.we_m;
			core_req.be = ctrl.we_m ? (ctrl.byte_en << off) : 4'b0000;
			core_req.addr = alu_y;
			core_req.wdata = rd2 << {off, 3'b000};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			pc <= '0;
			ir <= '0;
			halted <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (!run) begin
						halted <= 1'b0;
						pc <= '0;
					end else if (!halted) begin
						state <= S_FETCH;
					end
				end
				S_FETCH: begin
					if (core_gnt)
						state <= S_DECODE;
				end
				S_DECODE: begin
					ir <= core_rdata;
					state <= S_EXEC;
				end
				S_EXEC: begin
					if (ctrl.halt) begin
						halted <= 1'b1;
						state <= S_IDLE;
					end else if (ctrl.mem_rd || ctrl.we_m) begin
						state <= S_MEM;
					end else begin
						pc <= pc_next;
						state <= run ? S_FETCH : S_IDLE;
					end
				end
				S_MEM: begin
					if (core_gnt && ctrl.mem_rd) begin
						state <= S_WB;
					end else if (core_gnt) begin
						pc <= pc4;
						state <= run ? S_FETCH : S_IDLE;
					end
				end
				S_WB: begin
					pc <= pc4;
					state <= run ? S_FETCH : S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

	localparam int XLEN = 32;
	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = $clog2(MEM_WORDS);

	// instruction fields
	//   opcode [6:0], rd [11:7], fnct [14:12], rs1 [19:15], rs2 [24:20], fnct7 [31:25]
	// immediates
	//   I  = sext(ir[31:20])
	//   S  = sext({ir[31:25], ir[11:7]})
	//   SB = sext({ir[31:25], ir[11:7]}) << 1
	//   UJ = sext(ir[31:12]) << 1
	localparam logic [6:0] OP_R    = 7'b0000011;
	localparam logic [6:0] OP_R_I  = 7'b1000011;
	localparam logic [6:0] OP_I    = 7'b0000111;
	localparam logic [6:0] OP_S    = 7'b0001111;
	localparam logic [6:0] OP_SB   = 7'b0010011;
	localparam logic [6:0] OP_UJ   = 7'b0001011;
	localparam logic [6:0] OP_HALT = 7'b0000000;

	localparam logic [1:0] IMM_I  = 2'd0;
	localparam logic [1:0] IMM_S  = 2'd1;
	localparam logic [1:0] IMM_SB = 2'd2;
	localparam logic [1:0] IMM_UJ = 2'd3;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SLT  = 4'd1,
		ALU_SLTU = 4'd2,
		ALU_AND  = 4'd3,
		ALU_OR   = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SLL  = 4'd6,
		ALU_SRL  = 4'd7,
		ALU_SUB  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_op_t;

	// load width
	typedef enum logic [1:0] {
		EXT_W = 2'd0,
		EXT_H = 2'd1,
		EXT_B = 2'd2
	} ext_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       src_imm;
		logic [1:0] imm_kind;
		logic       signed_ext;
		ext_t       ext;
		logic       we_r;
		logic       we_m;
		logic       mem_rd;
		logic       brch;
		logic       jump;
		logic       wb_pc4;
		logic [3:0] byte_en;
		logic       halt;
	} ctrl_t;

	typedef struct packed {
		logic            req;
		logic            we;
		logic [3:0]      be;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} mem_req_t;

endpackage

/* src/cpu_regfile.sv */
`timescale 1ns/1ps

module cpu_regfile (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [4:0]               ra1,
	input  logic [4:0]               ra2,
	output logic [cpu_pkg::XLEN-1:0] rd1,
	output logic [cpu_pkg::XLEN-1:0] rd2,
	input  logic [4:0]               wa,
	input  logic [cpu_pkg::XLEN-1:0] wd,
	input  logic                     we
);

	logic [cpu_pkg::XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// x0 is never written, so it reads zero
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     run,
	input  cpu_pkg::mem_req_t        host_req,
	output logic [cpu_pkg::XLEN-1:0] host_rdata,
	output logic                     halted
);

	cpu_pkg::mem_req_t        core_req;
	cpu_pkg::mem_req_t        mem_req;
	logic                     core_gnt;
	logic [cpu_pkg::XLEN-1:0] core_rdata;
	logic [cpu_pkg::XLEN-1:0] mem_rdata;

	cpu_core u_core (
		.clk, .rst_n, .run, .core_req, .core_gnt, .core_rdata, .halted
	);

	mem_arbiter u_arb (
		.clk, .rst_n, .host_req, .core_req, .core_gnt, .mem_req,
		.mem_rdata, .host_rdata, .core_rdata
	);

	shared_mem u_mem (.clk, .mem_req, .rdata(mem_rdata));

endmodule

/* src/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cpu_pkg::mem_req_t        host_req,
	input  cpu_pkg::mem_req_t        core_req,
	output logic                     core_gnt,
	output cpu_pkg::mem_req_t        mem_req,
	input  logic [cpu_pkg::XLEN-1:0] mem_rdata,
	output logic [cpu_pkg::XLEN-1:0] host_rdata,
	output logic [cpu_pkg::XLEN-1:0] core_rdata
);

	logic                     host_q;
	logic                     core_q;
	logic [cpu_pkg::XLEN-1:0] host_hold;
	logic [cpu_pkg::XLEN-1:0] core_hold;

	// host always wins
	assign core_gnt = core_req.req & ~host_req.req;

	always_comb begin
		if (host_req.req)
			mem_req = host_req;
		else if (core_gnt)
			mem_req = core_req;
		else
			mem_req = '0;
	end

	// who owns the returning read data
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			host_q <= 1'b0;
			core_q <= 1'b0;
		end else begin
			host_q <= host_req.req;
			core_q <= core_gnt;
		end
	end

	always_ff @(posedge clk) begin
		host_hold <= host_rdata;
		core_hold <= core_rdata;
	end

	assign host_rdata = host_q ? mem_rdata : host_hold;
	assign core_rdata = core_q ? mem_rdata : core_hold;

endmodule

/* src/shared_mem.sv */
`timescale 1ns/1ps

module shared_mem (
	input  logic                     clk,
	input  cpu_pkg::mem_req_t        mem_req,
	output logic [cpu_pkg::XLEN-1:0] rdata
);

	logic [cpu_pkg::XLEN-1:0]   mem [cpu_pkg::MEM_WORDS];
	logic [cpu_pkg::MEM_AW-1:0] idx;

	// word index, byte address wraps at 1 KiB
	assign idx = mem_req.addr[cpu_pkg::MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (mem_req.req) begin
			if (mem_req.we) begin
				for (int i = 0; i < 4; i++) begin
					if (mem_req.be[i])
						mem[idx][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
				end
			end
			rdata <= mem[idx];
		end
	end

endmodule
